// File: common/core_pkg.sv
package core_pkg;

	localparam int reg_idx_w = 5;

	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// major opcodes of the supported subset.
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_branch = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	localparam logic [6:0] funct7_mul = 7'b0000001;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		opcode_e opcode;
	} i_fmt_t;

	// same 32-bit word, two field layouts.
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

endpackage

// File: design/decoder.sv
module decoder (
	input core_pkg::instr_u instr,
	input logic instr_valid,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::reg_idx_t rd,
	output logic [31:0] imm,
	output core_pkg::alu_op_e alu_op,
	output logic use_imm,
	output logic we_reg,
	output logic is_branch,
	output logic is_mul
);
	import core_pkg::*;

	always_comb begin
		rs1 = instr.r_fmt.rs1;
		rs2 = instr.r_fmt.rs2;
		rd = instr.r_fmt.rd;
		imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
		alu_op = alu_pass_b;
		use_imm = 1'b0;
		we_reg = 1'b0;
		is_branch = 1'b0;
		is_mul = 1'b0;
		if (instr_valid) begin
			case (instr.r_fmt.opcode)
				op_reg: begin
					we_reg = 1'b1;
					case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
						{7'b0000000, 3'b000}: alu_op = alu_add;
						{7'b0100000, 3'b000}: alu_op = alu_sub;
						{7'b0000000, 3'b111}: alu_op = alu_and;
						{7'b0000000, 3'b110}: alu_op = alu_or;
						{7'b0000000, 3'b100}: alu_op = alu_xor;
						{7'b0000000, 3'b010}: alu_op = alu_slt;
						{funct7_mul, 3'b000}: is_mul = 1'b1;
						default: we_reg = 1'b0; // unknown funct, bubble.
					endcase
				end
				op_imm: begin
					if (instr.i_fmt.funct3 == 3'b000) begin
						we_reg = 1'b1;
						use_imm = 1'b1;
						alu_op = alu_add;
					end
				end
				op_branch: begin
					is_branch = (instr.r_fmt.funct3 == 3'b000); // beq only.
					// B-type offset lives in the funct7 and rd slots.
					imm = {{19{instr.r_fmt.funct7[6]}}, instr.r_fmt.funct7[6], instr.r_fmt.rd[0],
						instr.r_fmt.funct7[5:0], instr.r_fmt.rd[4:1], 1'b0};
				end
				default: ;
			endcase
		end
	end

endmodule

// File: design/reg_file.sv
module reg_file #(
	parameter int data_width = 32
) (
	input logic clk,
	input logic arst_n,
	input core_pkg::reg_idx_t rs1,
	input core_pkg::reg_idx_t rs2,
	input logic we,
	input core_pkg::reg_idx_t wd_idx,
	input logic [data_width-1:0] wd,
	output logic [data_width-1:0] rd1,
	output logic [data_width-1:0] rd2
);
	import core_pkg::*;

	logic [data_width-1:0] regs [2**reg_idx_w];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**reg_idx_w; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wd_idx != '0) begin
			regs[wd_idx] <= wd;
		end
	end

	// x0 is hardwired, same-cycle write is passed through.
	assign rd1 = (rs1 == '0) ? '0 : (we && wd_idx == rs1) ? wd : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (we && wd_idx == rs2) ? wd : regs[rs2];

endmodule

// File: design/reg_exe.sv
module reg_exe #(
	parameter int data_width = 32
) (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic hold,
	input logic [data_width-1:0] src_a,
	input logic [data_width-1:0] src_b,
	input core_pkg::reg_idx_t rs1,
	input core_pkg::reg_idx_t rs2,
	input core_pkg::reg_idx_t rd,
	input logic [31:0] pc,
	input logic [31:0] imm,
	input core_pkg::alu_op_e alu_op,
	input logic use_imm,
	input logic we_reg,
	input logic is_branch,
	input logic is_mul,
	output logic [data_width-1:0] src_a_out,
	output logic [data_width-1:0] src_b_out,
	output core_pkg::reg_idx_t rs1_out,
	output core_pkg::reg_idx_t rs2_out,
	output core_pkg::reg_idx_t rd_out,
	output logic [31:0] pc_out,
	output logic [31:0] imm_out,
	output core_pkg::alu_op_e alu_op_out,
	output logic use_imm_out,
	output logic we_reg_out,
	output logic is_branch_out,
	output logic is_mul_out
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			we_reg_out <= 1'b0;
			is_branch_out <= 1'b0;
			is_mul_out <= 1'b0;
		end else if (flush) begin // squash to a bubble.
			we_reg_out <= 1'b0;
			is_branch_out <= 1'b0;
			is_mul_out <= 1'b0;
		end else if (!hold) begin
			we_reg_out <= we_reg;
			is_branch_out <= is_branch;
			is_mul_out <= is_mul;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			src_a_out <= src_a;
			src_b_out <= src_b;
			rs1_out <= rs1;
			rs2_out <= rs2;
			rd_out <= rd;
			pc_out <= pc;
			imm_out <= imm;
			alu_op_out <= alu_op;
			use_imm_out <= use_imm;
		end
	end

	// a taken branch and a running mul cannot share execute.
	a_flush_hold: assert property (@(posedge clk) disable iff (!arst_n) !(flush && hold))
		else $error("reg_exe: flush and hold high together");

endmodule

// File: design/execute_unit.sv
module execute_unit #(
	parameter int data_width = 32
) (
	input logic clk,
	input logic arst_n,
	input logic [data_width-1:0] src_a,
	input logic [data_width-1:0] src_b,
	input core_pkg::reg_idx_t rs1,
	input core_pkg::reg_idx_t rs2,
	input core_pkg::reg_idx_t rd,
	input logic [31:0] pc,
	input logic [31:0] imm,
	input core_pkg::alu_op_e alu_op,
	input logic use_imm,
	input logic we_reg,
	input logic is_branch,
	input logic is_mul,
	input logic mul_done,
	input logic [data_width-1:0] product,
	output logic [data_width-1:0] fwd_a,
	output logic [data_width-1:0] fwd_b,
	output logic wb_we,
	output core_pkg::reg_idx_t wb_rd,
	output logic [data_width-1:0] wb_data,
	output logic redirect,
	output logic [31:0] redirect_pc
);
	import core_pkg::*;

	logic [data_width-1:0] op_b;
	logic [data_width-1:0] alu_res;

	assign fwd_a = (wb_we && wb_rd != '0 && wb_rd == rs1) ? wb_data : src_a;
	assign fwd_b = (wb_we && wb_rd != '0 && wb_rd == rs2) ? wb_data : src_b;
	assign op_b = use_imm ? data_width'(imm) : fwd_b;

	always_comb begin
		case (alu_op)
			alu_add: alu_res = fwd_a + op_b;
			alu_sub: alu_res = fwd_a - op_b;
			alu_and: alu_res = fwd_a & op_b;
			alu_or: alu_res = fwd_a | op_b;
			alu_xor: alu_res = fwd_a ^ op_b;
			alu_slt: alu_res = {{(data_width-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
			alu_pass_b: alu_res = op_b;
			default: alu_res = '0;
		endcase
	end

	assign redirect = is_branch && (fwd_a == fwd_b); // beq taken.
	assign redirect_pc = pc + imm;

	// mul writes only once the product is ready.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= (we_reg && !is_mul) || mul_done;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= rd;
		wb_data <= mul_done ? product : alu_res;
	end

	a_no_redirect_in_mul: assert property (@(posedge clk) disable iff (!arst_n)
		is_mul |-> !redirect)
		else $error("execute_unit: redirect while mul in execute");

	a_done_with_mul: assert property (@(posedge clk) disable iff (!arst_n)
		mul_done |-> is_mul)
		else $error("execute_unit: mul done without mul in execute");

endmodule

// File: mul/mul_ctrl.sv
module mul_ctrl (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic last,
	output logic stall,
	output logic load,
	output logic step,
	output logic clear,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_finish
	} state_e;

	state_e state;
	state_e state_nxt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (start) state_nxt = st_run;
			st_run: if (last) state_nxt = st_finish;
			st_finish: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	assign load = (state == st_idle) && start;
	assign clear = load; // counter restarts with each new mul.
	assign step = (state == st_run);
	assign done = (state == st_finish);
	assign stall = load || step;

	a_last_in_run: assert property (@(posedge clk) disable iff (!arst_n)
		last |-> state == st_run)
		else $error("mul_ctrl: counter last outside run");

endmodule

// File: mul/mul_iter_counter.sv
module mul_iter_counter #(
	parameter int iterations = 32
) (
	input logic clk,
	input logic arst_n,
	input logic clear,
	input logic step,
	output logic last
);

	localparam int cnt_w = (iterations > 1) ? $clog2(iterations) : 1;

	logic [cnt_w-1:0] count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= cnt_w'(iterations - 1);
		end else if (step && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign last = step && (count == '0);

endmodule

// File: mul/mul_datapath.sv
module mul_datapath #(
	parameter int data_width = 32
) (
	input logic clk,
	input logic arst_n,
	input logic load,
	input logic step,
	input logic [data_width-1:0] a,
	input logic [data_width-1:0] b,
	output logic [data_width-1:0] product
);

	logic [data_width-1:0] mcand;
	logic [data_width-1:0] mplier;
	logic [data_width-1:0] acc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mcand <= '0;
			mplier <= '0;
			acc <= '0;
		end else if (load) begin
			mcand <= a;
			mplier <= b;
			acc <= '0;
		end else if (step) begin
			if (mplier[0]) begin
				acc <= acc + mcand; // low bits only.
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product = acc;

endmodule

// File: design/core_top.sv
module core_top #(
	parameter int data_width = 32
) (
	input logic clk,
	input logic arst_n,
	input core_pkg::instr_u instr,
	input logic instr_valid,
	input logic [31:0] pc,
	output logic stall,
	output logic wb_we,
	output core_pkg::reg_idx_t wb_rd,
	output logic [data_width-1:0] wb_data,
	output logic redirect,
	output logic [31:0] redirect_pc
);
	import core_pkg::*;

	reg_idx_t dec_rs1;
	reg_idx_t dec_rs2;
	reg_idx_t dec_rd;
	logic [31:0] dec_imm;
	alu_op_e dec_alu_op;
	logic dec_use_imm;
	logic dec_we_reg;
	logic dec_is_branch;
	logic dec_is_mul;
	logic [data_width-1:0] rf_rd1;
	logic [data_width-1:0] rf_rd2;
	logic [data_width-1:0] ex_src_a;
	logic [data_width-1:0] ex_src_b;
	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	reg_idx_t ex_rd;
	logic [31:0] ex_pc;
	logic [31:0] ex_imm;
	alu_op_e ex_alu_op;
	logic ex_use_imm;
	logic ex_we_reg;
	logic ex_is_branch;
	logic ex_is_mul;
	logic [data_width-1:0] fwd_a;
	logic [data_width-1:0] fwd_b;
	logic [data_width-1:0] product;
	logic mul_load;
	logic mul_step;
	logic mul_clear;
	logic mul_last;
	logic mul_done;

	decoder i_decoder (
		.instr(instr), .instr_valid(instr_valid),
		.rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm), .alu_op(dec_alu_op),
		.use_imm(dec_use_imm), .we_reg(dec_we_reg), .is_branch(dec_is_branch),
		.is_mul(dec_is_mul)
	);

	reg_file #(.data_width(data_width)) i_reg_file (
		.clk(clk), .arst_n(arst_n), .rs1(dec_rs1), .rs2(dec_rs2),
		.we(wb_we), .wd_idx(wb_rd), .wd(wb_data), .rd1(rf_rd1), .rd2(rf_rd2)
	);

	reg_exe #(.data_width(data_width)) i_reg_exe (
		.clk(clk), .arst_n(arst_n), .flush(redirect), .hold(stall),
		.src_a(rf_rd1), .src_b(rf_rd2), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
		.pc(pc), .imm(dec_imm), .alu_op(dec_alu_op), .use_imm(dec_use_imm),
		.we_reg(dec_we_reg), .is_branch(dec_is_branch), .is_mul(dec_is_mul),
		.src_a_out(ex_src_a), .src_b_out(ex_src_b), .rs1_out(ex_rs1), .rs2_out(ex_rs2),
		.rd_out(ex_rd), .pc_out(ex_pc), .imm_out(ex_imm), .alu_op_out(ex_alu_op),
		.use_imm_out(ex_use_imm), .we_reg_out(ex_we_reg), .is_branch_out(ex_is_branch),
		.is_mul_out(ex_is_mul)
	);

	execute_unit #(.data_width(data_width)) i_execute_unit (
		.clk(clk), .arst_n(arst_n), .src_a(ex_src_a), .src_b(ex_src_b),
		.rs1(ex_rs1), .rs2(ex_rs2), .rd(ex_rd), .pc(ex_pc), .imm(ex_imm),
		.alu_op(ex_alu_op), .use_imm(ex_use_imm), .we_reg(ex_we_reg),
		.is_branch(ex_is_branch), .is_mul(ex_is_mul), .mul_done(mul_done),
		.product(product), .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_we(wb_we), .wb_rd(wb_rd),
		.wb_data(wb_data), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	mul_ctrl i_mul_ctrl (
		.clk(clk), .arst_n(arst_n), .start(ex_is_mul), .last(mul_last),
		.stall(stall), .load(mul_load), .step(mul_step), .clear(mul_clear), .done(mul_done)
	);

	mul_iter_counter #(.iterations(data_width)) i_mul_iter_counter (
		.clk(clk), .arst_n(arst_n), .clear(mul_clear), .step(mul_step), .last(mul_last)
	);

	// operands are taken after forwarding.
	mul_datapath #(.data_width(data_width)) i_mul_datapath (
		.clk(clk), .arst_n(arst_n), .load(mul_load), .step(mul_step),
		.a(fwd_a), .b(fwd_b), .product(product)
	);

endmodule

// File: tests/core_tb.sv
module core_tb;

	localparam int data_width = 32;
	localparam int stall_limit = 2 * data_width + 10;

	typedef enum int {k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi, k_mul} kind_e;

	logic clk = 1'b0;
	logic arst_n;
	logic [31:0] instr;
	logic instr_valid;
	logic [31:0] pc;
	logic stall;
	logic wb_we;
	logic [4:0] wb_rd;
	logic [data_width-1:0] wb_data;
	logic redirect;
	logic [31:0] redirect_pc;

	logic [31:0] model_regs [32];
	logic [4:0] exp_rd_a [256];
	logic [31:0] exp_data_a [256];
	logic [4:0] exp_rd;
	logic [31:0] exp_data;
	int exp_cnt = 0;
	int wb_ptr = 0;
	int mul_seq = 0;
	logic exp_redirect = 1'b0;
	logic [31:0] exp_redirect_pc = '0;
	logic pend_taken = 1'b0;
	logic pend_mul = 1'b0;
	logic [31:0] pend_target = '0;
	logic squash_next = 1'b0;
	logic [31:0] branch_target = '0;
	logic [31:0] cur_pc = '0;
	integer seed = 3;

	core_top #(.data_width(data_width)) i_core_top (
		.clk(clk), .arst_n(arst_n), .instr(instr), .instr_valid(instr_valid), .pc(pc),
		.stall(stall), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	always #20 clk = ~clk;

	assign exp_rd = exp_rd_a[wb_ptr];
	assign exp_data = exp_data_a[wb_ptr];

	always @(negedge clk) begin
		if (arst_n && wb_we) begin
			wb_ptr <= wb_ptr + 1; // one retirement per strobe.
		end
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	// previous instruction is accepted on the edge this drives on.
	task automatic drive_word(input logic [31:0] word, input logic valid, input logic [31:0] pc_val,
		input logic is_mul, input logic taken, input logic [31:0] target);
		int waited;
		@(posedge clk);
		exp_redirect <= pend_taken;
		exp_redirect_pc <= pend_target;
		if (pend_mul) begin
			mul_seq <= mul_seq + 1;
		end
		pend_taken = taken;
		pend_target = target;
		pend_mul = is_mul;
		instr <= word;
		pc <= pc_val;
		instr_valid <= valid;
		waited = 0;
		@(negedge clk);
		while (stall) begin
			if (waited >= stall_limit) begin
				$display("stall stayed high for more than %0d cycles at %0t", stall_limit, $time);
				abort_run();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	function automatic logic [31:0] model_result(input kind_e kind, input logic [31:0] a,
		input logic [31:0] b, input logic [11:0] imm);
		case (kind)
			k_add: return a + b;
			k_sub: return a - b;
			k_and: return a & b;
			k_or: return a | b;
			k_xor: return a ^ b;
			k_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			k_mul: return a * b; // low half only.
			default: return a + {{20{imm[11]}}, imm};
		endcase
	endfunction

	task automatic issue_op(input kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		logic [31:0] word;
		logic [31:0] res;
		logic squashed;
		squashed = squash_next;
		squash_next = 1'b0;
		case (kind)
			k_sub: word = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_and: word = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
			k_or: word = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
			k_xor: word = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
			k_slt: word = {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
			k_mul: word = {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_addi: word = {imm, rs1, 3'b000, rd, 7'b0010011};
			default: word = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
		endcase
		res = model_result(kind, model_regs[rs1], model_regs[rs2], imm);
		if (!squashed) begin
			if (rd != 5'd0) begin
				model_regs[rd] = res;
			end
			exp_rd_a[exp_cnt] = rd;
			exp_data_a[exp_cnt] = res;
			exp_cnt++;
		end
		drive_word(word, 1'b1, cur_pc, kind == k_mul && !squashed, 1'b0, 32'h0);
		cur_pc = squashed ? branch_target : cur_pc + 32'd4;
	endtask

	task automatic issue_beq(input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] off);
		logic taken;
		logic [31:0] target;
		taken = model_regs[rs1] == model_regs[rs2];
		target = cur_pc + {{19{off[12]}}, off};
		drive_word({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011},
			1'b1, cur_pc, 1'b0, taken, target);
		squash_next = taken;
		branch_target = target;
		cur_pc = cur_pc + 32'd4;
	endtask

	a_reset_idle: assert property (@(negedge clk) !arst_n |-> (!stall && !wb_we && !redirect))
		else begin
			$display("stall, wb_we or redirect high during reset at %0t", $time);
			abort_run();
		end
	a_wb_expected: assert property (@(negedge clk) disable iff (!arst_n) wb_we |-> wb_ptr < exp_cnt)
		else begin
			$display("writeback at %0t with no instruction left to retire", $time);
			abort_run();
		end
	a_wb_rd: assert property (@(negedge clk) disable iff (!arst_n) wb_we |-> wb_rd == exp_rd)
		else begin
			$display("[ERROR] %0t wb_rd expected %0d actual %0d", $time, exp_rd, wb_rd);
			abort_run();
		end
	a_wb_data: assert property (@(negedge clk) disable iff (!arst_n) wb_we |-> wb_data == exp_data)
		else begin
			$display("[ERROR] %0t wb_data expected %h actual %h", $time, exp_data, wb_data);
			abort_run();
		end
	a_redirect: assert property (@(negedge clk) disable iff (!arst_n) redirect == exp_redirect)
		else begin
			$display("[ERROR] %0t redirect expected %b actual %b", $time, exp_redirect, redirect);
			abort_run();
		end
	a_redirect_pc: assert property (@(negedge clk) disable iff (!arst_n)
		redirect |-> redirect_pc == exp_redirect_pc)
		else begin
			$display("[ERROR] %0t redirect_pc expected %h actual %h", $time, exp_redirect_pc,
				redirect_pc);
			abort_run();
		end
	a_mul_stall: assert property (@(negedge clk) disable iff (!arst_n)
		mul_seq != $past(mul_seq) |-> stall)
		else begin
			$display("[ERROR] %0t stall expected 1 actual %b", $time, stall);
			abort_run();
		end

	initial begin
		int waited;
		kind_e kind;
		arst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		pc = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		issue_op(k_addi, 1, 0, 0, 12'd5);
		issue_op(k_addi, 2, 0, 0, 12'hffd);
		issue_op(k_add, 3, 1, 2, 0); // forward and bypass.
		issue_op(k_sub, 4, 3, 1, 0);
		issue_op(k_and, 5, 4, 2, 0);
		issue_op(k_or, 6, 5, 1, 0);
		issue_op(k_xor, 7, 6, 3, 0);
		issue_op(k_slt, 8, 2, 1, 0);
		issue_op(k_slt, 9, 1, 2, 0);
		issue_op(k_addi, 0, 1, 0, 12'd7);
		issue_op(k_add, 10, 0, 0, 0); // x0 still zero.
		issue_op(k_mul, 11, 1, 2, 0);
		issue_op(k_add, 12, 11, 1, 0);
		issue_op(k_mul, 13, 11, 11, 0);
		issue_op(k_mul, 14, 13, 2, 0);
		issue_op(k_addi, 15, 14, 0, 12'd1);
		issue_beq(1, 1, 13'd16);
		issue_op(k_addi, 16, 0, 0, 12'd99); // squashed.
		issue_op(k_addi, 17, 1, 0, 12'd1);
		issue_beq(1, 2, 13'd8);
		issue_op(k_addi, 18, 0, 0, 12'd42);
		issue_op(k_addi, 19, 18, 0, 12'd1);
		issue_op(k_mul, 20, 1, 1, 0);
		issue_beq(20, 20, 13'h1ff8);
		issue_op(k_mul, 21, 1, 1, 0); // squashed mul.
		issue_op(k_add, 22, 20, 17, 0);
		repeat (60) begin
			kind = kind_e'($unsigned($random(seed)) % 8);
			issue_op(kind, $random(seed), $random(seed), $random(seed), $random(seed));
		end
		repeat (3) drive_word(32'h0, 1'b0, cur_pc, 1'b0, 1'b0, 32'h0);
		waited = 0;
		while (wb_ptr != exp_cnt && waited < stall_limit) begin
			@(posedge clk);
			waited++;
		end
		if (wb_ptr == exp_cnt) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("only %0d of %0d writebacks seen", wb_ptr, exp_cnt);
			abort_run();
		end
	end

endmodule

// File: flist.f
common/core_pkg.sv
design/decoder.sv
design/reg_file.sv
design/reg_exe.sv
design/execute_unit.sv
mul/mul_ctrl.sv
mul/mul_iter_counter.sv
mul/mul_datapath.sv
design/core_top.sv
tests/core_tb.sv
